//--- hdl/capture_pkg.sv
package capture_pkg;

    ////////////////////
    // sizes
    ////////////////////

    // width of ADC samples and of command bytes
    localparam int DATA_SIZE = 8;

    localparam int MEM_DEPTH = 256;
    localparam int ADDR_SIZE = $clog2(MEM_DEPTH);

    // every 4th gated sample is stored until a SET_DECIM says otherwise
    localparam int DECIMATE_DEFAULT = 4;

    ////////////////////
    // encodings
    ////////////////////

    // SET_DECIM is the only opcode followed by a parameter byte
    typedef enum logic [7:0] {
        OP_SET_DECIM = 8'h01,
        OP_CLEAN     = 8'h02,
        OP_ARM       = 8'h03,
        OP_DUMP      = 8'h04
    } cmd_opcode_t;

    // WAIT and CAPTURE both count candidates and differ only in the gate level
    typedef enum logic [2:0] {
        ST_IDLE    = 3'd0,
        ST_WAIT    = 3'd1,
        ST_CAPTURE = 3'd2,
        ST_READY   = 3'd3,
        ST_FETCH   = 3'd4,
        ST_SHOW    = 3'd5
    } sampler_state_t;

endpackage

//--- hdl/sampler_cmd_if.sv
`timescale 1ns/100ps

interface sampler_cmd_if;
    import capture_pkg::*;

    // all strobes are one cycle wide and cmd_param only means something with cmd_decim
    logic                 cmd_decim;
    logic [DATA_SIZE-1:0] cmd_param;
    logic                 cmd_arm;
    logic                 cmd_dump;
    logic                 cmd_clean;

    modport decoder (
        output cmd_decim,
        output cmd_param,
        output cmd_arm,
        output cmd_dump,
        output cmd_clean
    );

    modport sampler (
        input cmd_decim,
        input cmd_param,
        input cmd_arm,
        input cmd_dump,
        input cmd_clean
    );

endinterface

//--- hdl/command_decoder.sv
`timescale 1ns/100ps

module command_decoder (
    input  logic                              i_clock,
    input  logic                              i_rst_n,
    input  logic                              i_cmd_strobe,
    input  logic [capture_pkg::DATA_SIZE-1:0] i_cmd_byte,
    sampler_cmd_if.decoder                    cmd
);
    import capture_pkg::*;

    typedef enum logic {
        PARSE_OPCODE,
        PARSE_PARAM
    } parse_state_t;

    parse_state_t parse_state;
    cmd_opcode_t  opcode;

    assign opcode = cmd_opcode_t'(i_cmd_byte);

    ////////////////////
    // byte parser
    ////////////////////

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            parse_state   <= PARSE_OPCODE;
            cmd.cmd_decim <= 1'b0;
            cmd.cmd_arm   <= 1'b0;
            cmd.cmd_dump  <= 1'b0;
            cmd.cmd_clean <= 1'b0;
        end else begin
            // strobes drop again one cycle after they rise
            cmd.cmd_decim <= 1'b0;
            cmd.cmd_arm   <= 1'b0;
            cmd.cmd_dump  <= 1'b0;
            cmd.cmd_clean <= 1'b0;
            if (i_cmd_strobe) begin
                if (parse_state == PARSE_PARAM) begin
                    cmd.cmd_decim <= 1'b1;
                    parse_state   <= PARSE_OPCODE;
                end else begin
                    case (opcode)
                        OP_SET_DECIM: parse_state   <= PARSE_PARAM;
                        OP_CLEAN:     cmd.cmd_clean <= 1'b1;
                        OP_ARM:       cmd.cmd_arm   <= 1'b1;
                        OP_DUMP:      cmd.cmd_dump  <= 1'b1;
                        // unknown bytes are simply dropped
                        default:      parse_state   <= PARSE_OPCODE;
                    endcase
                end
            end
        end
    end

    // a zero decimation would never store anything, so it is taken as 1
    always_ff @(posedge i_clock) begin
        if (i_cmd_strobe && parse_state == PARSE_PARAM) begin
            if (i_cmd_byte == '0) begin
                cmd.cmd_param <= DATA_SIZE'(1);
            end else begin
                cmd.cmd_param <= i_cmd_byte;
            end
        end
    end

endmodule

//--- hdl/sample_memory.sv
`timescale 1ns/100ps

module sample_memory (
    input  logic                              i_clock,
    input  logic                              i_rst_n,
    input  logic [capture_pkg::ADDR_SIZE-1:0] i_addr,
    input  logic                              i_write,
    input  logic [capture_pkg::DATA_SIZE-1:0] i_data,
    input  logic                              i_read,
    input  logic                              i_clean,
    output logic [capture_pkg::DATA_SIZE-1:0] o_data,
    output logic                              o_busy
);
    import capture_pkg::*;

    logic [DATA_SIZE-1:0] mem [MEM_DEPTH];
    logic [ADDR_SIZE-1:0] clean_addr;
    logic                 clean_last;

    assign clean_last = clean_addr == ADDR_SIZE'(MEM_DEPTH - 1);

    ////////////////////
    // clean engine
    ////////////////////

    // one word per clock, so busy lasts exactly MEM_DEPTH cycles
    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_busy     <= 1'b0;
            clean_addr <= '0;
        end else if (o_busy) begin
            clean_addr <= clean_addr + 1'b1;
            if (clean_last) begin
                o_busy <= 1'b0;
            end
        end else if (i_clean) begin
            o_busy     <= 1'b1;
            clean_addr <= '0;
        end
    end

    ////////////////////
    // storage
    ////////////////////

    always_ff @(posedge i_clock) begin
        if (o_busy) begin
            mem[clean_addr] <= '0;
        end else begin
            if (i_write) begin
                mem[i_addr] <= i_data;
            end
            if (i_read) begin
                o_data <= mem[i_addr];
            end
        end
    end

endmodule

//--- hdl/sampler.sv
`timescale 1ns/100ps

module sampler (
    input  logic                              i_clock,
    input  logic                              i_rst_n,
    input  logic                              i_adc_ready,
    input  logic [capture_pkg::DATA_SIZE-1:0] i_data,
    input  logic                              i_gate,
    input  logic                              i_next,
    sampler_cmd_if.sampler                    cmd,
    output logic [capture_pkg::ADDR_SIZE-1:0] o_mem_addr,
    output logic                              o_mem_write,
    output logic [capture_pkg::DATA_SIZE-1:0] o_mem_data,
    output logic                              o_mem_read,
    output logic                              o_mem_clean,
    input  logic [capture_pkg::DATA_SIZE-1:0] i_mem_data,
    input  logic                              i_mem_busy,
    output logic [capture_pkg::DATA_SIZE-1:0] o_data,
    output logic                              o_valid,
    output logic                              o_idle
);
    import capture_pkg::*;

    sampler_state_t       state;
    sampler_state_t       state_next;
    logic [DATA_SIZE-1:0] decim;
    logic [DATA_SIZE-1:0] cand_cnt;
    logic [ADDR_SIZE-1:0] addr;
    logic [DATA_SIZE-1:0] data_q;
    logic                 gate_q;
    logic                 next_d1;
    logic                 next_d2;
    logic                 next_rise;
    logic                 accept;
    logic                 candidate;
    logic                 take;
    logic                 last_addr;

    // commands are only honoured by an idle sampler with the memory free
    assign accept    = state == ST_IDLE && !i_mem_busy;
    assign candidate = (state == ST_WAIT || state == ST_CAPTURE) && gate_q;
    assign take      = i_adc_ready && candidate && cand_cnt == decim - 1'b1;
    assign last_addr = addr == ADDR_SIZE'(MEM_DEPTH - 1);

    ////////////////////
    // input registers
    ////////////////////

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            gate_q    <= 1'b0;
            next_d1   <= 1'b0;
            next_d2   <= 1'b0;
            next_rise <= 1'b0;
        end else begin
            gate_q    <= i_gate;
            next_d1   <= i_next;
            next_d2   <= next_d1;
            // the registered edge sets the 3 cycle distance to o_valid
            next_rise <= next_d1 && !next_d2;
        end
    end

    always_ff @(posedge i_clock) begin
        data_q <= i_data;
    end

    ////////////////////
    // state machine
    ////////////////////

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (accept && cmd.cmd_arm) begin
                    state_next = ST_WAIT;
                end else if (accept && cmd.cmd_dump) begin
                    state_next = ST_READY;
                end
            end
            ST_WAIT: begin
                if (take && last_addr) begin
                    state_next = ST_READY;
                end else if (gate_q) begin
                    state_next = ST_CAPTURE;
                end
            end
            ST_CAPTURE: begin
                if (take && last_addr) begin
                    state_next = ST_READY;
                end else if (!gate_q) begin
                    state_next = ST_WAIT;
                end
            end
            ST_READY: begin
                if (next_rise) begin
                    state_next = ST_FETCH;
                end
            end
            ST_FETCH: state_next = ST_SHOW;
            ST_SHOW:  state_next = last_addr ? ST_IDLE : ST_READY;
            default:  state_next = ST_IDLE;
        endcase
        // losing the ADC aborts whatever is in progress
        if (!i_adc_ready) begin
            state_next = ST_IDLE;
        end
    end

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state    <= ST_IDLE;
            decim    <= DATA_SIZE'(DECIMATE_DEFAULT);
            cand_cnt <= '0;
            addr     <= '0;
        end else begin
            state <= state_next;
            if (accept && cmd.cmd_decim) begin
                decim <= cmd.cmd_param;
            end
            if (!i_adc_ready) begin
                cand_cnt <= '0;
                addr     <= '0;
            end else begin
                case (state)
                    // arm and dump both begin at address 0
                    ST_IDLE: begin
                        cand_cnt <= '0;
                        addr     <= '0;
                    end
                    ST_WAIT, ST_CAPTURE: begin
                        if (take) begin
                            cand_cnt <= '0;
                            addr     <= last_addr ? '0 : addr + 1'b1;
                        end else if (candidate) begin
                            cand_cnt <= cand_cnt + 1'b1;
                        end
                    end
                    ST_SHOW: addr <= last_addr ? '0 : addr + 1'b1;
                    default: addr <= addr;
                endcase
            end
        end
    end

    ////////////////////
    // outputs
    ////////////////////

    assign o_mem_addr  = addr;
    assign o_mem_write = take;
    assign o_mem_data  = data_q;
    assign o_mem_read  = i_adc_ready && state == ST_FETCH;
    assign o_mem_clean = accept && cmd.cmd_clean;

    // the memory keeps the fetched word on its output until the next read
    assign o_data  = i_mem_data;
    assign o_valid = state == ST_SHOW;
    assign o_idle  = accept;

endmodule

//--- hdl/capture_top.sv
`timescale 1ns/100ps

module capture_top (
    input  logic                              i_clock,
    input  logic                              i_rst_n,
    input  logic                              i_adc_ready,
    input  logic [capture_pkg::DATA_SIZE-1:0] i_data,
    input  logic                              i_gate,
    input  logic                              i_next,
    input  logic                              i_cmd_strobe,
    input  logic [capture_pkg::DATA_SIZE-1:0] i_cmd_byte,
    output logic [capture_pkg::DATA_SIZE-1:0] o_data,
    output logic                              o_valid,
    output logic                              o_idle
);
    import capture_pkg::*;

    logic [ADDR_SIZE-1:0] mem_addr;
    logic                 mem_write;
    logic [DATA_SIZE-1:0] mem_wdata;
    logic                 mem_read;
    logic                 mem_clean;
    logic [DATA_SIZE-1:0] mem_rdata;
    logic                 mem_busy;

    sampler_cmd_if cmd_bus ();

    command_decoder u_decoder (
        .i_clock      (i_clock),
        .i_rst_n      (i_rst_n),
        .i_cmd_strobe (i_cmd_strobe),
        .i_cmd_byte   (i_cmd_byte),
        .cmd          (cmd_bus.decoder)
    );

    sampler u_sampler (
        .i_clock     (i_clock),
        .i_rst_n     (i_rst_n),
        .i_adc_ready (i_adc_ready),
        .i_data      (i_data),
        .i_gate      (i_gate),
        .i_next      (i_next),
        .cmd         (cmd_bus.sampler),
        .o_mem_addr  (mem_addr),
        .o_mem_write (mem_write),
        .o_mem_data  (mem_wdata),
        .o_mem_read  (mem_read),
        .o_mem_clean (mem_clean),
        .i_mem_data  (mem_rdata),
        .i_mem_busy  (mem_busy),
        .o_data      (o_data),
        .o_valid     (o_valid),
        .o_idle      (o_idle)
    );

    sample_memory u_memory (
        .i_clock (i_clock),
        .i_rst_n (i_rst_n),
        .i_addr  (mem_addr),
        .i_write (mem_write),
        .i_data  (mem_wdata),
        .i_read  (mem_read),
        .i_clean (mem_clean),
        .o_data  (mem_rdata),
        .o_busy  (mem_busy)
    );

endmodule

//--- test/capture_checker.sv
`timescale 1ns/100ps

module capture_checker (
    input logic                              i_clock,
    input logic                              i_rst_n,
    input logic                              i_adc_ready,
    input logic [capture_pkg::DATA_SIZE-1:0] i_data,
    input logic                              i_gate,
    input logic                              i_next,
    input logic                              i_cmd_strobe,
    input logic [capture_pkg::DATA_SIZE-1:0] i_cmd_byte,
    input logic [capture_pkg::DATA_SIZE-1:0] o_data,
    input logic                              o_valid,
    input logic                              o_idle
);
    import capture_pkg::*;

    int                   error_count = 0;
    int                   words_checked = 0;
    logic [DATA_SIZE-1:0] model [MEM_DEPTH];
    logic [DATA_SIZE-1:0] data_q;
    logic [DATA_SIZE-1:0] pend_param;
    int                   decim;
    int                   cand;
    int                   wr_addr;
    int                   rd_idx;
    int                   clean_left;
    int                   cycle;
    int                   rise_cycle;
    bit                   armed;
    bit                   reading;
    bit                   want_param;
    bit                   reset_checked;
    bit                   pend_arm;
    bit                   pend_dump;
    bit                   pend_clean;
    bit                   pend_decim;
    bit                   gate_q;
    bit                   next_q;
    bit                   valid_q;
    bit                   idle_q;

    always @(posedge i_clock) begin
        if (!i_rst_n) begin
            decim = DECIMATE_DEFAULT;
            {armed, reading, want_param, reset_checked} = '0;
            {pend_arm, pend_dump, pend_clean, pend_decim} = '0;
            {gate_q, next_q, valid_q, idle_q} = '0;
            cand = 0;
            wr_addr = 0;
            rd_idx = 0;
            clean_left = 0;
            cycle = 0;
            rise_cycle = -100;
        end else begin
            cycle++;
            if (!reset_checked) begin
                if (o_idle !== 1'b1 || o_valid !== 1'b0) begin
                    $display("error at %0t: after reset o_idle=%b o_valid=%b", $time,
                             o_idle, o_valid);
                    error_count++;
                end
                reset_checked = 1;
            end

            // the sampler uses the gate and data registered on the previous edge
            if (!i_adc_ready) begin
                armed = 0;
                reading = 0;
            end else if (armed && gate_q) begin
                cand++;
                if (cand == decim) begin
                    model[ADDR_SIZE'(wr_addr)] = data_q;
                    cand = 0;
                    wr_addr++;
                    if (wr_addr == MEM_DEPTH) begin
                        armed = 0;
                    end
                end
            end

            if (clean_left > 0) begin
                if (o_idle) begin
                    $display("error at %0t: o_idle high while the memory clears", $time);
                    error_count++;
                end
                clean_left--;
            end

            // commands decoded on the last edge take effect only in an idle sampler
            if (pend_decim && o_idle) begin
                decim = int'(pend_param);
            end
            if (pend_clean && o_idle) begin
                for (int i = 0; i < MEM_DEPTH; i++) begin
                    model[i] = '0;
                end
                clean_left = MEM_DEPTH;
            end
            if (pend_arm && o_idle && i_adc_ready) begin
                armed = 1;
                cand = 0;
                wr_addr = 0;
                rd_idx = 0;
                reading = 1;
            end
            if (pend_dump && o_idle && i_adc_ready) begin
                rd_idx = 0;
                reading = 1;
            end

            {pend_arm, pend_dump, pend_clean, pend_decim} = '0;
            if (i_cmd_strobe) begin
                if (want_param) begin
                    pend_decim = 1;
                    pend_param = (i_cmd_byte == '0) ? DATA_SIZE'(1) : i_cmd_byte;
                    want_param = 0;
                end else begin
                    case (i_cmd_byte)
                        OP_SET_DECIM: want_param = 1;
                        OP_CLEAN:     pend_clean = 1;
                        OP_ARM:       pend_arm = 1;
                        OP_DUMP:      pend_dump = 1;
                        default:      want_param = 0;
                    endcase
                end
            end

            if (i_next && !next_q) begin
                rise_cycle = cycle;
            end
            if (o_valid) begin
                if (valid_q) begin
                    $display("error at %0t: o_valid high for more than one cycle", $time);
                    error_count++;
                end
                // o_valid rises after the third edge following the one that saw i_next
                if (cycle - rise_cycle != 4) begin
                    $display("error at %0t: o_valid %0d cycles after i_next", $time,
                             cycle - rise_cycle - 1);
                    error_count++;
                end
                if (o_data !== model[ADDR_SIZE'(rd_idx % MEM_DEPTH)]) begin
                    $display("error at %0t: word %0d is %h, expected %h", $time, rd_idx,
                             o_data, model[ADDR_SIZE'(rd_idx % MEM_DEPTH)]);
                    error_count++;
                end
                words_checked++;
                rd_idx++;
            end

            if (o_idle && !idle_q && reading && i_adc_ready) begin
                if (rd_idx != MEM_DEPTH) begin
                    $display("readout ended after %0d of %0d words", rd_idx, MEM_DEPTH);
                    error_count++;
                end
                reading = 0;
            end

            gate_q = i_gate;
            data_q = i_data;
            next_q = i_next;
            valid_q = o_valid;
            idle_q = o_idle;
        end
    end

endmodule

//--- test/tb_capture_top.sv
`timescale 1ns/100ps

module tb_capture_top;
    import capture_pkg::*;

    localparam int K_CAPTURE = 0;
    localparam int K_CLEAN_DUMP = 1;
    localparam int K_ABORT = 2;
    localparam int NUM_STEPS = 7;

    typedef struct {
        int kind;
        int decim;
        int burst;
        int gap;
        bit poke;
    } step_t;

    logic                 i_clock;
    logic                 i_rst_n;
    logic                 i_adc_ready;
    logic [DATA_SIZE-1:0] i_data;
    logic                 i_gate;
    logic                 i_next;
    logic                 i_cmd_strobe;
    logic [DATA_SIZE-1:0] i_cmd_byte;
    logic [DATA_SIZE-1:0] o_data;
    logic                 o_valid;
    logic                 o_idle;

    step_t steps [NUM_STEPS];
    int    seed = 32'hbe55_2f16;
    int    cycles = 0;
    int    limit = 1000000;
    int    cur_decim = DECIMATE_DEFAULT;

    capture_top dut0 (.*);

    capture_checker checker0 (.*);

    always #20 i_clock = ~i_clock;

    always @(negedge i_clock) begin
        i_data = DATA_SIZE'($random(seed));
    end

    always @(posedge i_clock) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout after %0d cycles, the DUT stopped responding", cycles);
            $display("errors: %0d, words checked: %0d", checker0.error_count,
                     checker0.words_checked);
            $display("Simulation failed");
            $finish;
        end
    end

    // worst case runs with one gated cycle per burst
    function automatic int cycle_budget();
        int total;
        int dec;
        total = 0;
        dec = DECIMATE_DEFAULT;
        for (int i = 0; i < NUM_STEPS; i++) begin
            if (steps[i].decim >= 0) begin
                dec = (steps[i].decim == 0) ? 1 : steps[i].decim;
            end
            if (steps[i].kind == K_CAPTURE) begin
                total += MEM_DEPTH * dec * (1 + steps[i].gap) + MEM_DEPTH * 8 + 50;
            end else if (steps[i].kind == K_CLEAN_DUMP) begin
                total += MEM_DEPTH + MEM_DEPTH * 8 + 50;
            end else begin
                total += 60 * (1 + steps[i].gap) + 200;
            end
        end
        return 2 * total + 2000;
    endfunction

    task automatic send_byte(input logic [DATA_SIZE-1:0] b);
        i_cmd_strobe = 1'b1;
        i_cmd_byte = b;
        @(negedge i_clock);
        i_cmd_strobe = 1'b0;
        @(negedge i_clock);
    endtask

    task automatic wait_idle();
        while (!o_idle) begin
            @(negedge i_clock);
        end
    endtask

    task automatic drive_gate(input int needed, input int burst, input int gap);
        int done;
        int len;
        done = 0;
        while (done < needed) begin
            len = 1 + (($random(seed) & 32'h7fff_ffff) % burst);
            for (int j = 0; j < len && done < needed; j++) begin
                i_gate = 1'b1;
                @(negedge i_clock);
                done++;
            end
            i_gate = 1'b0;
            repeat (gap) @(negedge i_clock);
        end
        repeat (4) @(negedge i_clock);
    endtask

    task automatic read_all(input bit poke);
        for (int i = 0; i < MEM_DEPTH; i++) begin
            // an ARM while reading out must be dropped by the sampler
            if (poke && i == 100) begin
                send_byte(OP_ARM);
            end
            i_next = 1'b1;
            @(negedge i_clock);
            while (!o_valid) begin
                @(negedge i_clock);
            end
            i_next = 1'b0;
            @(negedge i_clock);
        end
        wait_idle();
    endtask

    initial begin
        steps[0] = '{K_CAPTURE, -1, 5, 3, 1'b0};
        steps[1] = '{K_CAPTURE, 1, 7, 2, 1'b0};
        steps[2] = '{K_CAPTURE, 3, 3, 4, 1'b1};
        steps[3] = '{K_CAPTURE, 0, 9, 1, 1'b0};
        steps[4] = '{K_CLEAN_DUMP, -1, 1, 1, 1'b0};
        steps[5] = '{K_ABORT, 2, 4, 2, 1'b0};
        steps[6] = '{K_CAPTURE, -1, 4, 2, 1'b0};
        limit = cycle_budget();

        i_clock = 1'b0;
        i_rst_n = 1'b0;
        i_adc_ready = 1'b1;
        i_data = '0;
        i_gate = 1'b0;
        i_next = 1'b0;
        i_cmd_strobe = 1'b0;
        i_cmd_byte = '0;
        repeat (10) @(negedge i_clock);
        i_rst_n = 1'b1;
        repeat (3) @(negedge i_clock);

        for (int s = 0; s < NUM_STEPS; s++) begin
            if (steps[s].decim >= 0) begin
                send_byte(OP_SET_DECIM);
                send_byte(DATA_SIZE'(steps[s].decim));
                cur_decim = (steps[s].decim == 0) ? 1 : steps[s].decim;
            end
            case (steps[s].kind)
                K_CAPTURE: begin
                    send_byte(OP_ARM);
                    drive_gate(MEM_DEPTH * cur_decim, steps[s].burst, steps[s].gap);
                    read_all(steps[s].poke);
                end
                K_CLEAN_DUMP: begin
                    send_byte(OP_CLEAN);
                    @(negedge i_clock);
                    wait_idle();
                    send_byte(OP_DUMP);
                    read_all(1'b0);
                end
                default: begin
                    send_byte(OP_ARM);
                    drive_gate(60, steps[s].burst, steps[s].gap);
                    i_adc_ready = 1'b0;
                    repeat (3) @(negedge i_clock);
                    i_adc_ready = 1'b1;
                    wait_idle();
                end
            endcase
            repeat (3) @(negedge i_clock);
        end

        $display("errors: %0d, words checked: %0d", checker0.error_count,
                 checker0.words_checked);
        if (checker0.error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- filelist.f
hdl/capture_pkg.sv
hdl/sampler_cmd_if.sv
hdl/command_decoder.sv
hdl/sample_memory.sv
hdl/sampler.sv
hdl/capture_top.sv
test/capture_checker.sv
test/tb_capture_top.sv

//--- Makefile
TOP := tb_capture_top
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f filelist.f --top-module capture_top
	verilator --lint-only --timing -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing -f filelist.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
